// ==== testbench/wb_input.dat ====
# num op pc rf_we waddr wdata csr wmask wvalue ex ecode esub vaddr found idx kill
# then exp_we exp_wnum exp_wdata exp_flush exp_entry exp_tlbcmd chk_reg(ff none) chk_val
01 0 1c000000 1 05 12345678 0 0 0 0 0 0 0 0 0 0 f 05 12345678 0 0 0 05 12345678
02 0 1c000004 1 00 ffffffff 0 0 0 0 0 0 0 0 0 0 f 00 ffffffff 0 0 0 00 00000000
03 0 1c000008 1 1f a5a5a5a5 0 0 0 0 0 0 0 0 0 0 f 1f a5a5a5a5 0 0 0 1f a5a5a5a5
04 2 1c00000c 1 06 99 40 ffffffff 11223344 0 0 0 0 0 0 0 f 06 0 0 0 0 06 0
05 2 1c000010 1 07 99 40 0000ffff aaaabbbb 0 0 0 0 0 0 0 f 07 11223344 0 0 0 07 11223344
06 1 1c000014 1 08 99 40 0 0 0 0 0 0 0 0 0 f 08 1122bbbb 0 0 0 08 1122bbbb
07 4 1c000018 1 09 99 0 0 0 0 0 0 0 0 0 0 f 09 1122bbbb 0 0 0 09 1122bbbb
08 3 1c00001c 1 0a 99 40 ff000000 55000000 0 0 0 0 0 0 0 f 0a 1122bbbb 0 0 0 0a 1122bbbb
09 1 1c000020 1 0b 99 40 0 0 0 0 0 0 0 0 0 f 0b 5522bbbb 0 0 0 0b 5522bbbb
0a 2 1c000024 1 0c 99 c ffffffff 1c008000 0 0 0 0 0 0 0 f 0c 0 0 0 0 ff 0
0b 2 1c000028 1 0d 99 88 ffffffff 1c00f000 0 0 0 0 0 0 0 f 0d 0 0 0 0 ff 0
0c 2 1c00002c 1 0e 99 0 00000007 00000007 0 0 0 0 0 0 0 f 0e 0 0 0 0 ff 0
0d 0 1c000030 1 0f 1 0 0 0 1 0b 1 0 0 0 1 0 0f 0 1 1c008000 0 1f a5a5a5a5
0e 1 1c000034 1 10 99 6 0 0 0 0 0 0 0 0 0 f 10 1c000030 0 0 0 10 1c000030
0f 1 1c000038 1 11 99 5 0 0 0 0 0 0 0 0 0 f 11 004b0000 0 0 0 11 004b0000
10 1 1c00003c 1 12 99 1 0 0 0 0 0 0 0 0 0 f 12 00000007 0 0 0 12 00000007
11 1 1c000040 1 13 99 0 0 0 0 0 0 0 0 0 0 f 13 00000000 0 0 0 13 00000000
12 5 1c000044 0 00 0 0 0 0 0 0 0 0 0 0 0 0 00 0 1 1c000030 0 ff 0
13 1 1c000048 1 14 99 0 0 0 0 0 0 0 0 0 0 f 14 00000007 0 0 0 14 00000007
14 0 1c00004c 0 00 0 0 0 0 1 3f 0 00401234 0 0 0 0 00 0 1 1c00f000 0 ff 0
15 1 1c000050 1 15 99 7 0 0 0 0 0 0 0 0 0 f 15 00401234 0 0 0 15 00401234
16 1 1c000054 1 16 99 5 0 0 0 0 0 0 0 0 0 f 16 003f0000 0 0 0 16 003f0000
17 7 1c000058 0 00 0 0 0 0 0 0 0 0 0 0 0 0 00 0 1 1c00005c 1 ff 0
18 8 1c00005c 0 00 0 0 0 0 0 0 0 0 0 0 0 0 00 0 1 1c000060 2 ff 0
19 9 1c000060 0 00 0 0 0 0 0 0 0 0 0 0 0 0 00 0 1 1c000064 3 ff 0
1a a 1c000064 0 00 0 0 0 0 0 0 0 0 0 0 0 0 00 0 1 1c000068 0 ff 0
1b 6 1c000068 0 00 0 0 0 0 0 0 0 0 1 5 0 0 00 0 0 0 0 ff 0
1c 1 1c00006c 1 17 99 10 0 0 0 0 0 0 0 0 0 f 17 00000005 0 0 0 17 00000005
1d 6 1c000070 0 00 0 0 0 0 0 0 0 0 0 9 0 0 00 0 0 0 0 ff 0
1e 1 1c000074 1 18 99 10 0 0 0 0 0 0 0 0 0 f 18 80000005 0 0 0 18 80000005
1f 1 1c000078 1 19 99 6 0 0 0 0 0 0 0 0 0 f 19 1c00004c 0 0 0 19 1c00004c

// ==== filelist.f ====
+incdir+hdl
hdl/wb_pkg.sv
hdl/wb_stage.sv
hdl/wb_control.sv
hdl/csr_file.sv
hdl/reg_file.sv
hdl/wb_subsys_top.sv
testbench/tb_clock.sv
testbench/tb_wb_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the writeback testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_wb_subsys -f filelist.f \
    && ./obj_dir/Vtb_wb_subsys | tee /dev/stderr | grep -x "Test OK" > /dev/null \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

// ==== testbench/tb_wb_subsys.sv ====
`include "wb_consts.svh"

module tb_wb_subsys import wb_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic                     clk;
    logic                     resetn;
    logic                     mem_valid;
    logic [`WB_XLEN-1:0]      mem_pc;
    wb_op_e                   mem_op;
    logic                     mem_rf_we;
    logic [`WB_REG_AW-1:0]    mem_rf_waddr;
    logic [`WB_XLEN-1:0]      mem_rf_wdata;
    logic [`WB_CSR_NUM_W-1:0] mem_csr_num;
    logic [`WB_XLEN-1:0]      mem_csr_wmask;
    logic [`WB_XLEN-1:0]      mem_csr_wvalue;
    logic                     mem_ex;
    logic [`ECODE_W-1:0]      mem_ecode;
    logic [`ESUBCODE_W-1:0]   mem_esubcode;
    logic [`WB_XLEN-1:0]      mem_vaddr;
    logic                     mem_srch_found;
    logic [`TLB_IDX_W-1:0]    mem_srch_idx;
    logic [`WB_XLEN-1:0]      debug_wb_pc;
    logic [3:0]               debug_wb_rf_we;
    logic [`WB_REG_AW-1:0]    debug_wb_rf_wnum;
    logic [`WB_XLEN-1:0]      debug_wb_rf_wdata;
    logic                     wb_flush;
    logic [`WB_XLEN-1:0]      wb_flush_entry;
    tlb_cmd_e                 tlb_cmd;
    logic [`WB_REG_AW-1:0]    rf_raddr;
    logic [`WB_XLEN-1:0]      rf_rdata;

    int seed = 87;
    int cycles = 0;
    int limit = 0;          // set once the record count is known
    int test_errs;
    int errors = 0;
    int passed = 0;
    int failed = 0;

    tb_clock u_clock (.clk(clk), .resetn(resetn));

    wb_subsys_top dut (.*);

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    // random payload with valid low that must leave no trace
    task automatic drive_idle();
        logic [31:0] rnd;
        mem_valid      = 1'b0;
        rnd            = $random(seed);
        mem_pc         = rnd;
        mem_op         = wb_op_e'(rnd[3:0]);
        mem_rf_we      = rnd[4];
        mem_rf_waddr   = rnd[9:5];
        mem_ex         = rnd[10];
        mem_ecode      = rnd[16:11];
        mem_esubcode   = rnd[25:17];
        mem_srch_found = rnd[26];
        mem_srch_idx   = rnd[30:27];
        rnd            = $random(seed);
        mem_rf_wdata   = rnd;
        mem_csr_num    = rnd[13:0];
        rnd            = $random(seed);
        mem_csr_wmask  = rnd;
        mem_csr_wvalue = ~rnd;
        mem_vaddr      = rnd ^ 32'h5a5a5a5a;
    endtask

    // alu write to r31 that arrives while an exception retires
    task automatic drive_intruder();
        drive_idle();
        mem_valid    = 1'b1;
        mem_op       = op_alu;
        mem_rf_we    = 1'b1;
        mem_rf_waddr = 5'd31;
        mem_rf_wdata = 32'hbad0bad0;
        mem_ex       = 1'b0;
    endtask

    task automatic run_record(input string line);
        logic [31:0] num, op, pc, we, waddr, wdata, cnum, wmask, wval, ex, ecode, esub;
        logic [31:0] vaddr, found, idx, kill, e_we, e_wnum, e_wdata, e_flush, e_entry;
        logic [31:0] e_cmd, c_reg, c_val;
        int n;
        test_errs = 0;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    num, op, pc, we, waddr, wdata, cnum, wmask, wval, ex, ecode, esub,
                    vaddr, found, idx, kill, e_we, e_wnum, e_wdata, e_flush, e_entry,
                    e_cmd, c_reg, c_val);
        if (n != 24) begin
            $display("record line could not be parsed: %s", line);
            test_errs++;
            num = 0;
        end else begin
            mem_valid      = 1'b1;
            mem_pc         = pc;
            mem_op         = wb_op_e'(op[3:0]);
            mem_rf_we      = we[0];
            mem_rf_waddr   = waddr[4:0];
            mem_rf_wdata   = wdata;
            mem_csr_num    = cnum[13:0];
            mem_csr_wmask  = wmask;
            mem_csr_wvalue = wval;
            mem_ex         = ex[0];
            mem_ecode      = ecode[5:0];
            mem_esubcode   = esub[8:0];
            mem_vaddr      = vaddr;
            mem_srch_found = found[0];
            mem_srch_idx   = idx[3:0];
            rf_raddr       = c_reg[4:0];
            @(negedge clk);
            // instruction sits in writeback now
            check_value("trace pc", debug_wb_pc, pc);
            check_value("trace rf_we", 32'(debug_wb_rf_we), e_we);
            if (e_we != 0) begin
                check_value("trace wnum", 32'(debug_wb_rf_wnum), e_wnum);
                check_value("trace wdata", debug_wb_rf_wdata, e_wdata);
            end
            check_value("flush", 32'(wb_flush), e_flush);
            if (e_flush != 0) begin
                check_value("flush entry", wb_flush_entry, e_entry);
            end
            check_value("tlb_cmd", 32'(tlb_cmd), e_cmd);
            if (kill != 0) begin
                drive_intruder();
            end else begin
                drive_idle();
            end
            @(negedge clk);
            check_value("idle rf_we", 32'(debug_wb_rf_we), 0);
            check_value("idle flush", 32'(wb_flush), 0);
            check_value("idle tlb_cmd", 32'(tlb_cmd), 0);
            if (c_reg < 32) begin
                check_value($sformatf("r%0d readback", c_reg), rf_rdata, c_val);
            end
            if (kill != 0) begin
                // a leaked intruder write lands at the edge after the idle cycle
                drive_idle();
                @(negedge clk);
                if (c_reg < 32) begin
                    check_value($sformatf("r%0d after kill", c_reg), rf_rdata, c_val);
                end
            end
        end
        $display("test %0d: %s", num, (test_errs == 0) ? "pass" : "fail");
    endtask

    initial begin
        string recs[$];
        string line;
        int fd;
        mem_valid = 1'b0;
        rf_raddr  = '0;
        drive_idle();
        @(posedge resetn);
        fd = $fopen("testbench/wb_input.dat", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file testbench/wb_input.dat");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 4 && line[0] != "#") begin
                    recs.push_back(line);
                end
            end
            $fclose(fd);
            limit = recs.size() * 4 + 100;
            if (recs.size() == 0) begin
                $display("the stimulus file holds no records");
                errors++;
            end
            foreach (recs[i]) begin
                run_record(recs[i]);
                errors += test_errs;
                if (test_errs == 0) begin
                    passed++;
                end else begin
                    failed++;
                end
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                 passed + failed, passed, failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (limit == 0 || cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run went past %0d clock cycles", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== testbench/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic resetn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    // reset held for 16 rising edges, released on a falling edge
    initial begin
        resetn = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

// ==== hdl/wb_subsys_top.sv ====
`include "wb_consts.svh"

module wb_subsys_top import wb_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     mem_valid,
    input  logic [`WB_XLEN-1:0]      mem_pc,
    input  wb_op_e                   mem_op,
    input  logic                     mem_rf_we,
    input  logic [`WB_REG_AW-1:0]    mem_rf_waddr,
    input  logic [`WB_XLEN-1:0]      mem_rf_wdata,
    input  logic [`WB_CSR_NUM_W-1:0] mem_csr_num,
    input  logic [`WB_XLEN-1:0]      mem_csr_wmask,
    input  logic [`WB_XLEN-1:0]      mem_csr_wvalue,
    input  logic                     mem_ex,
    input  logic [`ECODE_W-1:0]      mem_ecode,
    input  logic [`ESUBCODE_W-1:0]   mem_esubcode,
    input  logic [`WB_XLEN-1:0]      mem_vaddr,
    input  logic                     mem_srch_found,
    input  logic [`TLB_IDX_W-1:0]    mem_srch_idx,
    output logic [`WB_XLEN-1:0]      debug_wb_pc,
    output logic [3:0]               debug_wb_rf_we,
    output logic [`WB_REG_AW-1:0]    debug_wb_rf_wnum,
    output logic [`WB_XLEN-1:0]      debug_wb_rf_wdata,
    output logic                     wb_flush,
    output logic [`WB_XLEN-1:0]      wb_flush_entry,
    output tlb_cmd_e                 tlb_cmd,
    input  logic [`WB_REG_AW-1:0]    rf_raddr,   // stands in for decode
    output logic [`WB_XLEN-1:0]      rf_rdata
);
    // stage payload
    logic                     load;
    logic [`WB_XLEN-1:0]      wb_pc;
    wb_op_e                   wb_op;
    logic                     wb_rf_we_raw;
    logic [`WB_REG_AW-1:0]    wb_rf_waddr;
    logic [`WB_XLEN-1:0]      wb_final_wdata;
    logic [`WB_CSR_NUM_W-1:0] wb_csr_num;
    logic [`WB_XLEN-1:0]      wb_csr_wmask;
    logic [`WB_XLEN-1:0]      wb_csr_wvalue;
    logic                     wb_excep;
    logic [`ECODE_W-1:0]      wb_ecode;
    logic [`ESUBCODE_W-1:0]   wb_esubcode;
    logic [`WB_XLEN-1:0]      wb_vaddr;
    logic                     wb_srch_found;
    logic [`TLB_IDX_W-1:0]    wb_srch_idx;

    // control to csr and register file
    logic                     wb_ex;
    logic                     ertn_flush;
    logic                     rf_we;
    logic                     csr_re;
    logic                     csr_we;
    logic [`WB_CSR_NUM_W-1:0] csr_num;
    logic [`WB_XLEN-1:0]      csr_rvalue;
    logic                     tlbsrch_we;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wnum  = wb_rf_waddr;
    assign debug_wb_rf_wdata = wb_final_wdata;

    wb_stage u_stage (.*);

    wb_control u_control (
        .wb_valid (),   // only used inside the controller
        .*
    );

    csr_file u_csr (
        .csr_wmask  (wb_csr_wmask),
        .csr_wvalue (wb_csr_wvalue),
        .*
    );

    reg_file u_rf (
        .clk   (clk),
        .we    (rf_we),
        .waddr (wb_rf_waddr),
        .wdata (wb_final_wdata),
        .raddr (rf_raddr),
        .rdata (rf_rdata)
    );

endmodule

// ==== hdl/reg_file.sv ====
`include "wb_consts.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  we,
    input  logic [`WB_REG_AW-1:0] waddr,
    input  logic [`WB_XLEN-1:0]   wdata,
    input  logic [`WB_REG_AW-1:0] raddr,
    output logic [`WB_XLEN-1:0]   rdata
);
    logic [`WB_XLEN-1:0] regs [`WB_NREGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin   // writes to r0 are dropped
            regs[waddr] <= wdata;
        end
    end

    assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

// ==== hdl/csr_file.sv ====
`include "wb_consts.svh"

module csr_file (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     csr_re,
    input  logic [`WB_CSR_NUM_W-1:0] csr_num,
    input  logic                     csr_we,
    input  logic [`WB_XLEN-1:0]      csr_wmask,
    input  logic [`WB_XLEN-1:0]      csr_wvalue,
    input  logic                     wb_ex,
    input  logic [`ECODE_W-1:0]      wb_ecode,
    input  logic [`ESUBCODE_W-1:0]   wb_esubcode,
    input  logic [`WB_XLEN-1:0]      wb_pc,
    input  logic [`WB_XLEN-1:0]      wb_vaddr,
    input  logic                     ertn_flush,
    input  logic                     tlbsrch_we,
    input  logic                     wb_srch_found,
    input  logic [`TLB_IDX_W-1:0]    wb_srch_idx,
    output logic [`WB_XLEN-1:0]      csr_rvalue
);
    logic [`WB_XLEN-1:0]    rd_value;
    logic [`WB_XLEN-1:0]    wr_value;     // masked merge of old and new

    logic [1:0]             crmd_plv;
    logic                   crmd_ie;
    logic [1:0]             prmd_pplv;
    logic                   prmd_pie;
    logic [1:0]             estat_is;     // software interrupt bits only
    logic [`ECODE_W-1:0]    estat_ecode;
    logic [`ESUBCODE_W-1:0] estat_esubcode;
    logic [`WB_XLEN-1:0]    era;
    logic [`WB_XLEN-1:0]    badv;
    logic [25:0]            eentry_va;    // 64-byte aligned
    logic [25:0]            tlbrentry_pa;
    logic [`WB_XLEN-1:0]    tid;
    logic                   tlbidx_ne;
    logic [5:0]             tlbidx_ps;
    logic [`TLB_IDX_W-1:0]  tlbidx_index;

    always_comb begin
        case (csr_num)
            `CSR_CRMD:      rd_value = {29'b0, crmd_ie, crmd_plv};
            `CSR_PRMD:      rd_value = {29'b0, prmd_pie, prmd_pplv};
            `CSR_ESTAT:     rd_value = {1'b0, estat_esubcode, estat_ecode, 14'b0, estat_is};
            `CSR_ERA:       rd_value = era;
            `CSR_BADV:      rd_value = badv;
            `CSR_EENTRY:    rd_value = {eentry_va, 6'b0};
            `CSR_TLBRENTRY: rd_value = {tlbrentry_pa, 6'b0};
            `CSR_TID:       rd_value = tid;
            `CSR_TLBIDX:    rd_value = {tlbidx_ne, 1'b0, tlbidx_ps,
                                        {(24 - `TLB_IDX_W){1'b0}}, tlbidx_index};
            default:        rd_value = '0;
        endcase
    end

    assign csr_rvalue = csr_re ? rd_value : '0;
    assign wr_value   = (rd_value & ~csr_wmask) | (csr_wvalue & csr_wmask);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv       <= 2'b0;     // plv0, interrupts off
            crmd_ie        <= 1'b0;
            prmd_pplv      <= 2'b0;
            prmd_pie       <= 1'b0;
            estat_is       <= 2'b0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era            <= '0;
            badv           <= '0;
            eentry_va      <= '0;
            tlbrentry_pa   <= '0;
            tid            <= '0;
            tlbidx_ne      <= 1'b0;
            tlbidx_ps      <= '0;
            tlbidx_index   <= '0;
        end else if (wb_ex) begin
            prmd_pplv      <= crmd_plv;  // save mode for ertn
            prmd_pie       <= crmd_ie;
            crmd_plv       <= 2'b0;
            crmd_ie        <= 1'b0;
            era            <= wb_pc;
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
            if (wb_ecode == `ECODE_TLBR || wb_ecode == `ECODE_ADE) begin
                badv <= wb_vaddr;
            end
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (tlbsrch_we) begin
            tlbidx_ne <= ~wb_srch_found;
            if (wb_srch_found) begin
                tlbidx_index <= wb_srch_idx;
            end
        end else if (csr_we) begin
            case (csr_num)
                `CSR_CRMD: begin
                    crmd_plv <= wr_value[1:0];
                    crmd_ie  <= wr_value[2];
                end
                `CSR_PRMD: begin
                    prmd_pplv <= wr_value[1:0];
                    prmd_pie  <= wr_value[2];
                end
                `CSR_ESTAT:     estat_is     <= wr_value[1:0];
                `CSR_ERA:       era          <= wr_value;
                `CSR_BADV:      badv         <= wr_value;
                `CSR_EENTRY:    eentry_va    <= wr_value[31:6];
                `CSR_TLBRENTRY: tlbrentry_pa <= wr_value[31:6];
                `CSR_TID:       tid          <= wr_value;
                `CSR_TLBIDX: begin
                    tlbidx_ne    <= wr_value[31];
                    tlbidx_ps    <= wr_value[29:24];
                    tlbidx_index <= wr_value[`TLB_IDX_W-1:0];
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== hdl/wb_control.sv ====
`include "wb_consts.svh"

module wb_control import wb_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     mem_valid,
    input  logic [`WB_XLEN-1:0]      wb_pc,
    input  wb_op_e                   wb_op,
    input  logic                     wb_rf_we_raw,
    input  logic [`WB_CSR_NUM_W-1:0] wb_csr_num,
    input  logic                     wb_excep,
    input  logic [`ECODE_W-1:0]      wb_ecode,
    input  logic [`WB_XLEN-1:0]      csr_rvalue,
    output logic                     load,
    output logic                     wb_valid,
    output logic                     wb_ex,
    output logic                     ertn_flush,
    output logic                     rf_we,
    output logic                     csr_re,
    output logic                     csr_we,
    output logic [`WB_CSR_NUM_W-1:0] csr_num,
    output logic                     tlbsrch_we,
    output logic                     wb_flush,
    output logic [`WB_XLEN-1:0]      wb_flush_entry,
    output tlb_cmd_e                 tlb_cmd,
    output logic [3:0]               debug_wb_rf_we
);
    logic retire;       // valid and not excepting
    logic csr_access;
    logic refetch;

    // anything arriving while we redirect is dropped
    assign load = mem_valid & ~wb_ex & ~ertn_flush;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_ex || ertn_flush) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid;
        end
    end

    assign retire     = wb_valid & ~wb_excep;
    assign wb_ex      = wb_valid & wb_excep;
    assign ertn_flush = retire & (wb_op == op_ertn);

    assign csr_access = wb_op inside {op_csrrd, op_csrwr, op_csrxchg, op_rdcntid};
    assign csr_re     = wb_ex | ertn_flush | (retire & csr_access);
    assign csr_we     = retire & (wb_op inside {op_csrwr, op_csrxchg});
    assign tlbsrch_we = retire & (wb_op == op_tlbsrch);

    // csr read port also fetches the redirect target
    always_comb begin
        if (wb_ex && wb_ecode == `ECODE_TLBR) begin
            csr_num = `CSR_TLBRENTRY;
        end else if (wb_ex) begin
            csr_num = `CSR_EENTRY;
        end else if (ertn_flush) begin
            csr_num = `CSR_ERA;
        end else if (wb_op == op_rdcntid) begin
            csr_num = `CSR_TID;
        end else begin
            csr_num = wb_csr_num;
        end
    end

    always_comb begin
        tlb_cmd = tlb_none;
        if (retire) begin
            case (wb_op)
                op_tlbwr:   tlb_cmd = tlb_wr;
                op_tlbfill: tlb_cmd = tlb_fill;
                op_tlbrd:   tlb_cmd = tlb_rd;
                default:    tlb_cmd = tlb_none;
            endcase
        end
    end

    // tlb maintenance changes translation, so restart at the next pc
    assign refetch = retire & (wb_op inside {op_tlbwr, op_tlbfill, op_tlbrd, op_invtlb});

    assign wb_flush       = wb_ex | ertn_flush | refetch;
    assign wb_flush_entry = (wb_ex || ertn_flush) ? csr_rvalue : wb_pc + `WB_XLEN'd4;

    assign rf_we          = retire & wb_rf_we_raw;
    assign debug_wb_rf_we = {4{rf_we}};

endmodule

// ==== hdl/wb_stage.sv ====
`include "wb_consts.svh"

module wb_stage import wb_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     load,
    input  logic [`WB_XLEN-1:0]      mem_pc,
    input  wb_op_e                   mem_op,
    input  logic                     mem_rf_we,
    input  logic [`WB_REG_AW-1:0]    mem_rf_waddr,
    input  logic [`WB_XLEN-1:0]      mem_rf_wdata,
    input  logic [`WB_CSR_NUM_W-1:0] mem_csr_num,
    input  logic [`WB_XLEN-1:0]      mem_csr_wmask,
    input  logic [`WB_XLEN-1:0]      mem_csr_wvalue,
    input  logic                     mem_ex,
    input  logic [`ECODE_W-1:0]      mem_ecode,
    input  logic [`ESUBCODE_W-1:0]   mem_esubcode,
    input  logic [`WB_XLEN-1:0]      mem_vaddr,
    input  logic                     mem_srch_found,
    input  logic [`TLB_IDX_W-1:0]    mem_srch_idx,
    input  logic [`WB_XLEN-1:0]      csr_rvalue,
    output logic [`WB_XLEN-1:0]      wb_pc,
    output wb_op_e                   wb_op,
    output logic                     wb_rf_we_raw,
    output logic [`WB_REG_AW-1:0]    wb_rf_waddr,
    output logic [`WB_XLEN-1:0]      wb_final_wdata,
    output logic [`WB_CSR_NUM_W-1:0] wb_csr_num,
    output logic [`WB_XLEN-1:0]      wb_csr_wmask,
    output logic [`WB_XLEN-1:0]      wb_csr_wvalue,
    output logic                     wb_excep,
    output logic [`ECODE_W-1:0]      wb_ecode,
    output logic [`ESUBCODE_W-1:0]   wb_esubcode,
    output logic [`WB_XLEN-1:0]      wb_vaddr,
    output logic                     wb_srch_found,
    output logic [`TLB_IDX_W-1:0]    wb_srch_idx
);
    logic [`WB_XLEN-1:0] wb_rf_wdata;   // alu or load result

    // fields that decide side effects
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_op        <= op_alu;
            wb_rf_we_raw <= 1'b0;
            wb_excep     <= 1'b0;
        end else if (load) begin
            wb_op        <= mem_op;
            wb_rf_we_raw <= mem_rf_we;
            wb_excep     <= mem_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            wb_pc         <= mem_pc;
            wb_rf_waddr   <= mem_rf_waddr;
            wb_rf_wdata   <= mem_rf_wdata;
            wb_csr_num    <= mem_csr_num;
            wb_csr_wmask  <= mem_csr_wmask;
            wb_csr_wvalue <= mem_csr_wvalue;
            wb_ecode      <= mem_ecode;
            wb_esubcode   <= mem_esubcode;
            wb_vaddr      <= mem_vaddr;
            wb_srch_found <= mem_srch_found;
            wb_srch_idx   <= mem_srch_idx;
        end
    end

    // csr ops return the old csr value, rdcntid returns tid
    assign wb_final_wdata = (wb_op inside {op_csrrd, op_csrwr, op_csrxchg, op_rdcntid}) ?
                            csr_rvalue : wb_rf_wdata;

endmodule

// ==== hdl/wb_pkg.sv ====
package wb_pkg;

    // what the retiring instruction does at writeback
    typedef enum logic [3:0] {
        op_alu,       // plain result or load data
        op_csrrd,
        op_csrwr,
        op_csrxchg,
        op_rdcntid,   // reads tid through the csr port
        op_ertn,
        op_tlbsrch,
        op_tlbwr,
        op_tlbfill,
        op_tlbrd,
        op_invtlb
    } wb_op_e;

    // command strobe towards the tlb array
    typedef enum logic [1:0] {
        tlb_none,
        tlb_wr,
        tlb_fill,
        tlb_rd
    } tlb_cmd_e;

endpackage

// ==== hdl/wb_consts.svh ====
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// datapath widths
`define WB_XLEN       32
`define WB_CSR_NUM_W  14
`define WB_NREGS      32
`define WB_REG_AW     5
`define TLB_IDX_W     4       // 16-entry tlb

// csr numbers
`define CSR_CRMD      14'h000
`define CSR_PRMD      14'h001
`define CSR_ESTAT     14'h005
`define CSR_ERA       14'h006
`define CSR_BADV      14'h007
`define CSR_EENTRY    14'h00c
`define CSR_TLBIDX    14'h010
`define CSR_TID       14'h040
`define CSR_TLBRENTRY 14'h088

// exception codes
`define ECODE_W       6
`define ESUBCODE_W    9
`define ECODE_ADE     6'h08   // address error, badv recorded
`define ECODE_TLBR    6'h3f   // tlb refill, goes to tlbrentry

`endif
